// ==== hdl/pcs_rx_pkg.sv ====
package pcs_rx_pkg;

	// sync header values
	localparam logic [1:0] SYNC_DATA = 2'b01;
	localparam logic [1:0] SYNC_CTRL = 2'b10;

	// block type field, low payload byte of a control block
	localparam logic [7:0] BT_IDLE  = 8'h1E;
	localparam logic [7:0] BT_START = 8'h78;

	// terminate types, the digit is the data byte count before /T/
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'hAA;
	localparam logic [7:0] BT_TERM3 = 8'hB4;
	localparam logic [7:0] BT_TERM4 = 8'hCC;
	localparam logic [7:0] BT_TERM5 = 8'hD2;
	localparam logic [7:0] BT_TERM6 = 8'hE1;
	localparam logic [7:0] BT_TERM7 = 8'hFF;

	// xgmii control characters
	localparam logic [7:0] XGMII_IDLE  = 8'h07;
	localparam logic [7:0] XGMII_START = 8'hFB;
	localparam logic [7:0] XGMII_TERM  = 8'hFD;
	localparam logic [7:0] XGMII_ERROR = 8'hFE;

	typedef struct packed {
		logic [1:0]  sync;    // 01 data, 10 control
		logic [63:0] payload; // block type field in [7:0] for control blocks
	} rx_block_t;

	typedef struct packed {
		logic [63:0] data; // lane 0 in [7:0]
		logic [7:0]  ctrl; // one bit per lane
	} xgmii_word_t;

	typedef enum logic [2:0] {
		TYPE_D,
		TYPE_S,
		TYPE_C,
		TYPE_T,
		TYPE_E
	} r_type_e;

	typedef enum logic [2:0] {
		RX_INIT,
		RX_C,
		RX_D,
		RX_T,
		RX_E
	} rx_state_e;

	typedef struct packed {
		rx_block_t block;
		r_type_e   r_type;
	} typed_block_t;

	localparam xgmii_word_t ERROR_WORD = '{data: {8{XGMII_ERROR}}, ctrl: 8'hFF};

endpackage

// ==== hdl/rx_block_classifier.sv ====
`timescale 1ns/1ns

module rx_block_classifier
(
	input  pcs_rx_pkg::rx_block_t    i_block,
	output pcs_rx_pkg::typed_block_t o_typed
);

	logic [7:0]          block_type;
	logic                codes_zero; // all eight 7-bit control codes clear
	pcs_rx_pkg::r_type_e r_type;

	assign block_type = i_block.payload[7:0];
	assign codes_zero = (i_block.payload[63:8] == 56'd0);

	always_comb
	begin
		r_type = pcs_rx_pkg::TYPE_E;
		case (i_block.sync)
			pcs_rx_pkg::SYNC_DATA:
			begin
				r_type = pcs_rx_pkg::TYPE_D;
			end
			pcs_rx_pkg::SYNC_CTRL:
			begin
				case (block_type)
					pcs_rx_pkg::BT_IDLE:
					begin
						// idle only counts when every code is /I/
						r_type = codes_zero ? pcs_rx_pkg::TYPE_C : pcs_rx_pkg::TYPE_E;
					end
					pcs_rx_pkg::BT_START:
						r_type = pcs_rx_pkg::TYPE_S;
					pcs_rx_pkg::BT_TERM0,
					pcs_rx_pkg::BT_TERM1,
					pcs_rx_pkg::BT_TERM2,
					pcs_rx_pkg::BT_TERM3,
					pcs_rx_pkg::BT_TERM4,
					pcs_rx_pkg::BT_TERM5,
					pcs_rx_pkg::BT_TERM6,
					pcs_rx_pkg::BT_TERM7:
						r_type = pcs_rx_pkg::TYPE_T;
					default:
						r_type = pcs_rx_pkg::TYPE_E; // unknown type field
				endcase
			end
			default:
			begin
				r_type = pcs_rx_pkg::TYPE_E; // 00 and 11 are not valid headers
			end
		endcase
	end

	assign o_typed.block  = i_block;
	assign o_typed.r_type = r_type;

endmodule

// ==== hdl/rx_block_lookahead.sv ====
`timescale 1ns/1ns

module rx_block_lookahead
(
	input  logic                     i_clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_rx_pkg::typed_block_t i_typed,
	output pcs_rx_pkg::typed_block_t o_held,
	output pcs_rx_pkg::r_type_e      o_r_type_next,
	output logic                     o_full
);

	pcs_rx_pkg::typed_block_t held;
	logic                     full;

	// fill flag, set once the first block is in
	always_ff @(posedge i_clock or posedge i_reset)
	begin
		if (i_reset)
		begin
			full <= 1'b0;
		end
		else if (i_valid)
		begin
			full <= 1'b1;
		end
	end

	// block under decision
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			held <= i_typed;
		end
	end

	assign o_held        = held;
	assign o_full        = full;
	assign o_r_type_next = i_typed.r_type; // arriving block is the lookahead

endmodule

// ==== hdl/rx_xgmii_mapper.sv ====
`timescale 1ns/1ns

module rx_xgmii_mapper
(
	input  pcs_rx_pkg::rx_block_t   i_block,
	output pcs_rx_pkg::xgmii_word_t o_word
);

	logic [7:0]  block_type;
	logic [63:0] term_bytes; // payload bytes 1 to 7 moved down to lane 0
	logic [2:0]  term_count;
	logic        is_term;

	assign block_type = i_block.payload[7:0];
	assign term_bytes = {8'h00, i_block.payload[63:8]};

	// number of data bytes ahead of /T/
	always_comb
	begin
		is_term    = 1'b1;
		term_count = 3'd0;
		case (block_type)
			pcs_rx_pkg::BT_TERM0: term_count = 3'd0;
			pcs_rx_pkg::BT_TERM1: term_count = 3'd1;
			pcs_rx_pkg::BT_TERM2: term_count = 3'd2;
			pcs_rx_pkg::BT_TERM3: term_count = 3'd3;
			pcs_rx_pkg::BT_TERM4: term_count = 3'd4;
			pcs_rx_pkg::BT_TERM5: term_count = 3'd5;
			pcs_rx_pkg::BT_TERM6: term_count = 3'd6;
			pcs_rx_pkg::BT_TERM7: term_count = 3'd7;
			default:              is_term    = 1'b0;
		endcase
	end

	always_comb
	begin
		o_word = pcs_rx_pkg::ERROR_WORD;
		if (i_block.sync == pcs_rx_pkg::SYNC_DATA)
		begin
			o_word.data = i_block.payload;
			o_word.ctrl = 8'h00;
		end
		else if (i_block.sync == pcs_rx_pkg::SYNC_CTRL)
		begin
			if (block_type == pcs_rx_pkg::BT_IDLE)
			begin
				o_word.data = {8{pcs_rx_pkg::XGMII_IDLE}};
				o_word.ctrl = 8'hFF;
			end
			else if (block_type == pcs_rx_pkg::BT_START)
			begin
				// /S/ in lane 0, data in lanes 1 to 7
				o_word.data = {i_block.payload[63:8], pcs_rx_pkg::XGMII_START};
				o_word.ctrl = 8'h01;
			end
			else if (is_term)
			begin
				for (int lane = 0; lane < 8; lane++)
				begin
					if (lane < int'(term_count))
					begin
						o_word.data[8*lane +: 8] = term_bytes[8*lane +: 8];
						o_word.ctrl[lane]        = 1'b0;
					end
					else if (lane == int'(term_count))
					begin
						o_word.data[8*lane +: 8] = pcs_rx_pkg::XGMII_TERM;
						o_word.ctrl[lane]        = 1'b1;
					end
					else
					begin
						o_word.data[8*lane +: 8] = pcs_rx_pkg::XGMII_IDLE; // idle fill after /T/
						o_word.ctrl[lane]        = 1'b1;
					end
				end
			end
		end
	end

endmodule

// ==== hdl/rx_decode_fsm.sv ====
`timescale 1ns/1ns

module rx_decode_fsm
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_valid,
	input  logic                    i_full,
	input  pcs_rx_pkg::r_type_e     i_r_type,
	input  pcs_rx_pkg::r_type_e     i_r_type_next,
	input  pcs_rx_pkg::xgmii_word_t i_mapped,
	output logic                    o_valid,
	output pcs_rx_pkg::xgmii_word_t o_xgmii,
	output logic                    o_block_error
);

	pcs_rx_pkg::rx_state_e state;
	pcs_rx_pkg::rx_state_e state_next;
	logic                  step;       // a held block is decided on this beat
	logic                  next_ok;    // following block may close a frame
	logic                  block_bad;

	assign step    = i_valid & i_full;
	assign next_ok = (i_r_type_next == pcs_rx_pkg::TYPE_S) ||
	                 (i_r_type_next == pcs_rx_pkg::TYPE_C);

	always_comb
	begin
		state_next = pcs_rx_pkg::RX_E;
		case (state)
			pcs_rx_pkg::RX_INIT,
			pcs_rx_pkg::RX_C,
			pcs_rx_pkg::RX_T:
			begin
				case (i_r_type)
					pcs_rx_pkg::TYPE_C: state_next = pcs_rx_pkg::RX_C;
					pcs_rx_pkg::TYPE_S: state_next = pcs_rx_pkg::RX_D;
					default:            state_next = pcs_rx_pkg::RX_E;
				endcase
			end
			pcs_rx_pkg::RX_D:
			begin
				// inside a frame only data or a well placed terminate
				case (i_r_type)
					pcs_rx_pkg::TYPE_D: state_next = pcs_rx_pkg::RX_D;
					pcs_rx_pkg::TYPE_T: state_next = next_ok ? pcs_rx_pkg::RX_T : pcs_rx_pkg::RX_E;
					default:            state_next = pcs_rx_pkg::RX_E;
				endcase
			end
			pcs_rx_pkg::RX_E:
			begin
				// recovery, any legal block resumes decoding
				case (i_r_type)
					pcs_rx_pkg::TYPE_C: state_next = pcs_rx_pkg::RX_C;
					pcs_rx_pkg::TYPE_S: state_next = pcs_rx_pkg::RX_D;
					pcs_rx_pkg::TYPE_D: state_next = pcs_rx_pkg::RX_D;
					pcs_rx_pkg::TYPE_T: state_next = next_ok ? pcs_rx_pkg::RX_T : pcs_rx_pkg::RX_E;
					default:            state_next = pcs_rx_pkg::RX_E;
				endcase
			end
			default:
			begin
				state_next = pcs_rx_pkg::RX_E;
			end
		endcase
	end

	assign block_bad = (state_next == pcs_rx_pkg::RX_E);

	always_ff @(posedge i_clock or posedge i_reset)
	begin
		if (i_reset)
		begin
			state         <= pcs_rx_pkg::RX_INIT;
			o_valid       <= 1'b0;
			o_block_error <= 1'b0;
			o_xgmii       <= '0;
		end
		else
		begin
			o_valid       <= step; // one cycle pulse per decided block
			o_block_error <= step & block_bad;
			if (step)
			begin
				state   <= state_next;
				o_xgmii <= block_bad ? pcs_rx_pkg::ERROR_WORD : i_mapped;
			end
		end
	end

endmodule

// ==== hdl/pcs_rx_decoder.sv ====
`timescale 1ns/1ns

module pcs_rx_decoder
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_valid,
	input  pcs_rx_pkg::rx_block_t   i_block,
	output logic                    o_valid,
	output pcs_rx_pkg::xgmii_word_t o_xgmii,
	output logic                    o_block_error
);

	pcs_rx_pkg::typed_block_t typed_block; // arriving block with its type
	pcs_rx_pkg::typed_block_t held_block;  // block under decision
	pcs_rx_pkg::r_type_e      r_type_next;
	pcs_rx_pkg::xgmii_word_t  mapped_word;
	logic                     lookahead_full;

	rx_block_classifier rx_block_classifier_i
	(
		.i_block (i_block),
		.o_typed (typed_block)
	);

	rx_block_lookahead rx_block_lookahead_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_typed       (typed_block),
		.o_held        (held_block),
		.o_r_type_next (r_type_next),
		.o_full        (lookahead_full)
	);

	rx_xgmii_mapper rx_xgmii_mapper_i
	(
		.i_block (held_block.block),
		.o_word  (mapped_word)
	);

	rx_decode_fsm rx_decode_fsm_i
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_full        (lookahead_full),
		.i_r_type      (held_block.r_type),
		.i_r_type_next (r_type_next),
		.i_mapped      (mapped_word),
		.o_valid       (o_valid),
		.o_xgmii       (o_xgmii),
		.o_block_error (o_block_error)
	);

endmodule

// ==== verification/pcs_rx_decoder_assertions.sv ====
`timescale 1ns/1ns

module pcs_rx_decoder_assertions
(
	input logic                    i_clock,
	input logic                    i_reset,
	input logic                    i_valid,
	input logic                    o_valid,
	input pcs_rx_pkg::xgmii_word_t o_xgmii,
	input logic                    o_block_error
);

	// every output word comes from a beat one clock earlier
	valid_after_beat: assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid |-> $past(i_valid))
		else $error("o_valid high without an input beat on the previous cycle");

	error_with_valid: assert property (@(posedge i_clock) disable iff (i_reset)
		o_block_error |-> o_valid)
		else $error("o_block_error high while o_valid is low");

	error_word_out: assert property (@(posedge i_clock) disable iff (i_reset)
		o_block_error |-> (o_xgmii == pcs_rx_pkg::ERROR_WORD))
		else $error("o_block_error high but o_xgmii is not the error word");

endmodule

// ==== verification/pcs_rx_checker.sv ====
`timescale 1ns/1ns

module pcs_rx_checker
(
	input  logic                    i_clock,
	input  logic                    i_reset,
	input  logic                    i_valid,
	input  pcs_rx_pkg::rx_block_t   i_block,
	input  logic                    o_valid,
	input  pcs_rx_pkg::xgmii_word_t o_xgmii,
	input  logic                    o_block_error,
	output int                      value_errors,
	output int                      timing_errors,
	output int                      pending
);

	localparam logic [7:0] TERM_TYPES [8] = '{pcs_rx_pkg::BT_TERM0, pcs_rx_pkg::BT_TERM1,
		pcs_rx_pkg::BT_TERM2, pcs_rx_pkg::BT_TERM3, pcs_rx_pkg::BT_TERM4,
		pcs_rx_pkg::BT_TERM5, pcs_rx_pkg::BT_TERM6, pcs_rx_pkg::BT_TERM7};

	pcs_rx_pkg::xgmii_word_t exp_words [$];
	logic                    exp_errors [$];
	pcs_rx_pkg::rx_block_t   held;
	logic                    held_full;
	logic                    exp_valid; // a decision was made on the last beat
	pcs_rx_pkg::rx_state_e   state;

	// data byte count of a terminate, -1 for anything else
	function automatic int term_len(input logic [7:0] bt);
		for (int i = 0; i < 8; i++)
			if (bt == TERM_TYPES[i])
				return i;
		return -1;
	endfunction

	function automatic pcs_rx_pkg::r_type_e type_of(input pcs_rx_pkg::rx_block_t b);
		if (b.sync == pcs_rx_pkg::SYNC_DATA)
			return pcs_rx_pkg::TYPE_D;
		if (b.sync != pcs_rx_pkg::SYNC_CTRL)
			return pcs_rx_pkg::TYPE_E;
		if (b.payload[7:0] == pcs_rx_pkg::BT_IDLE)
			return (b.payload[63:8] == '0) ? pcs_rx_pkg::TYPE_C : pcs_rx_pkg::TYPE_E;
		if (b.payload[7:0] == pcs_rx_pkg::BT_START)
			return pcs_rx_pkg::TYPE_S;
		if (term_len(b.payload[7:0]) >= 0)
			return pcs_rx_pkg::TYPE_T;
		return pcs_rx_pkg::TYPE_E;
	endfunction

	function automatic pcs_rx_pkg::xgmii_word_t word_of(input pcs_rx_pkg::rx_block_t b);
		pcs_rx_pkg::xgmii_word_t w;
		int                      n;
		w = pcs_rx_pkg::ERROR_WORD;
		n = term_len(b.payload[7:0]);
		case (type_of(b))
			pcs_rx_pkg::TYPE_D: w = '{data: b.payload, ctrl: 8'h00};
			pcs_rx_pkg::TYPE_C: w = '{data: {8{pcs_rx_pkg::XGMII_IDLE}}, ctrl: 8'hFF};
			pcs_rx_pkg::TYPE_S: w = '{data: {b.payload[63:8], pcs_rx_pkg::XGMII_START}, ctrl: 8'h01};
			pcs_rx_pkg::TYPE_T:
			begin
				for (int lane = 0; lane < 8; lane++)
				begin
					w.ctrl[lane] = (lane >= n);
					if (lane < n)
						w.data[8*lane +: 8] = b.payload[8*(lane+1) +: 8];
					else
						w.data[8*lane +: 8] = (lane == n) ? pcs_rx_pkg::XGMII_TERM : pcs_rx_pkg::XGMII_IDLE;
				end
			end
			default: w = pcs_rx_pkg::ERROR_WORD;
		endcase
		return w;
	endfunction

	function automatic pcs_rx_pkg::rx_state_e next_state(input pcs_rx_pkg::rx_state_e s,
		input pcs_rx_pkg::r_type_e t, input pcs_rx_pkg::r_type_e nt);
		bit closes;
		bit in_frame;
		closes   = (nt == pcs_rx_pkg::TYPE_S) || (nt == pcs_rx_pkg::TYPE_C);
		in_frame = (s == pcs_rx_pkg::RX_D) || (s == pcs_rx_pkg::RX_E);
		if (t == pcs_rx_pkg::TYPE_C && s != pcs_rx_pkg::RX_D)
			return pcs_rx_pkg::RX_C;
		if (t == pcs_rx_pkg::TYPE_S && s != pcs_rx_pkg::RX_D)
			return pcs_rx_pkg::RX_D;
		if (t == pcs_rx_pkg::TYPE_D && in_frame)
			return pcs_rx_pkg::RX_D;
		if (t == pcs_rx_pkg::TYPE_T && in_frame && closes)
			return pcs_rx_pkg::RX_T;
		return pcs_rx_pkg::RX_E;
	endfunction

	always @(posedge i_clock)
	begin : model
		pcs_rx_pkg::xgmii_word_t want;
		logic                    want_err;
		pcs_rx_pkg::rx_state_e   s_next;
		if (i_reset)
		begin
			held_full     = 1'b0;
			exp_valid     = 1'b0;
			state         = pcs_rx_pkg::RX_INIT;
			value_errors  = 0;
			timing_errors = 0;
			exp_words.delete();
			exp_errors.delete();
		end
		else
		begin
			if (o_valid !== exp_valid)
			begin
				timing_errors++;
				$display("** Error at %0t: o_valid is %b, expected %b", $time, o_valid, exp_valid);
			end
			if (o_valid === 1'b1 && exp_words.size() == 0)
			begin
				value_errors++;
				$display("** Error at %0t: output word with no block pending", $time);
			end
			else if (o_valid === 1'b1)
			begin
				want     = exp_words.pop_front();
				want_err = exp_errors.pop_front();
				if (o_xgmii !== want || o_block_error !== want_err)
				begin
					value_errors++;
					$display("** Error at %0t: got %h err %b, expected %h err %b",
						$time, o_xgmii, o_block_error, want, want_err);
				end
			end
			exp_valid = i_valid && held_full;
			if (i_valid)
			begin
				if (held_full)
				begin
					s_next = next_state(state, type_of(held), type_of(i_block));
					exp_words.push_back((s_next == pcs_rx_pkg::RX_E) ? pcs_rx_pkg::ERROR_WORD
						: word_of(held));
					exp_errors.push_back(s_next == pcs_rx_pkg::RX_E);
					state = s_next;
				end
				held      = i_block;
				held_full = 1'b1;
			end
		end
		pending = exp_words.size();
	end

endmodule

// ==== verification/pcs_rx_decoder_tb.sv ====
`timescale 1ns/1ns

module pcs_rx_decoder_tb;

	localparam int NUM_BLOCKS  = 3000;
	localparam int CYCLE_LIMIT = NUM_BLOCKS * 5 + 200;
	localparam logic [7:0] TERM_TYPES [8] = '{pcs_rx_pkg::BT_TERM0, pcs_rx_pkg::BT_TERM1,
		pcs_rx_pkg::BT_TERM2, pcs_rx_pkg::BT_TERM3, pcs_rx_pkg::BT_TERM4,
		pcs_rx_pkg::BT_TERM5, pcs_rx_pkg::BT_TERM6, pcs_rx_pkg::BT_TERM7};

	logic                    i_clock;
	logic                    i_reset;
	logic                    i_valid;
	pcs_rx_pkg::rx_block_t   i_block;
	logic                    o_valid;
	pcs_rx_pkg::xgmii_word_t o_xgmii;
	logic                    o_block_error;
	int                      value_errors;
	int                      timing_errors;
	int                      pending;
	int                      sent = 0;
	int                      cycles = 0;

	pcs_rx_decoder pcs_rx_decoder_i
	(
		.i_clock (i_clock), .i_reset (i_reset), .i_valid (i_valid), .i_block (i_block),
		.o_valid (o_valid), .o_xgmii (o_xgmii), .o_block_error (o_block_error)
	);

	pcs_rx_checker pcs_rx_checker_i
	(
		.i_clock (i_clock), .i_reset (i_reset), .i_valid (i_valid), .i_block (i_block),
		.o_valid (o_valid), .o_xgmii (o_xgmii), .o_block_error (o_block_error),
		.value_errors (value_errors), .timing_errors (timing_errors), .pending (pending)
	);

	bind pcs_rx_decoder pcs_rx_decoder_assertions pcs_rx_decoder_assertions_i
	(
		.i_clock (i_clock), .i_reset (i_reset), .i_valid (i_valid),
		.o_valid (o_valid), .o_xgmii (o_xgmii), .o_block_error (o_block_error)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #10 i_clock = ~i_clock;
	end

	always @(posedge i_clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [63:0] random_bits();
		return {$urandom(), $urandom()};
	endfunction

	// one accepted beat with random gaps of about 20%
	task automatic drive_beat(input pcs_rx_pkg::rx_block_t blk);
		bit gap;
		if (sent >= NUM_BLOCKS)
			return;
		do
		begin
			@(posedge i_clock);
			gap = ($urandom_range(99) >= 80);
			if (gap)
			begin
				i_valid <= 1'b0;
				i_block <= '{sync: 2'b01, payload: random_bits()}; // junk, not sampled
			end
		end while (gap);
		i_valid <= 1'b1;
		i_block <= blk;
		sent++;
	endtask

	// corrupts about 5% of blocks before they go out
	task automatic send_block(input pcs_rx_pkg::rx_block_t blk, input bit is_term);
		if ($urandom_range(99) < 5)
		begin
			case ($urandom_range(3))
				0: blk.sync = $urandom_range(1) ? 2'b00 : 2'b11;
				1: blk.payload[7:0] = 8'h55; // unknown block type
				2:
				begin
					if (is_term)
						return; // frame loses its terminate
					blk = '{sync: pcs_rx_pkg::SYNC_CTRL, payload: {56'h1, pcs_rx_pkg::BT_IDLE}};
				end
				default: drive_beat('{sync: pcs_rx_pkg::SYNC_DATA, payload: random_bits()});
			endcase
		end
		drive_beat(blk);
	endtask

	task automatic send_frame();
		logic [63:0] bits;
		repeat ($urandom_range(4, 1))
			send_block('{sync: pcs_rx_pkg::SYNC_CTRL, payload: {56'h0, pcs_rx_pkg::BT_IDLE}}, 0);
		bits = random_bits();
		send_block('{sync: pcs_rx_pkg::SYNC_CTRL, payload: {bits[55:0], pcs_rx_pkg::BT_START}}, 0);
		repeat ($urandom_range(6, 0))
			send_block('{sync: pcs_rx_pkg::SYNC_DATA, payload: random_bits()}, 0);
		bits = random_bits();
		send_block('{sync: pcs_rx_pkg::SYNC_CTRL,
			payload: {bits[55:0], TERM_TYPES[$urandom_range(7)]}}, 1);
	endtask

	initial
	begin
		void'($urandom(32'h16f6cd6a));
		i_reset <= 1'b1;
		i_valid <= 1'b0;
		i_block <= '0;
		repeat (16) @(posedge i_clock);
		i_reset <= 1'b0;
		while (sent < NUM_BLOCKS)
			send_frame();
		@(posedge i_clock);
		i_valid <= 1'b0;
		repeat (3) @(negedge i_clock); // last word comes out one clock after the final beat
		$display("errors: %0d value, %0d timing, %0d words missing",
			value_errors, timing_errors, pending);
		if (value_errors == 0 && timing_errors == 0 && pending == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/pcs_rx_pkg.sv
hdl/rx_block_classifier.sv
hdl/rx_block_lookahead.sv
hdl/rx_xgmii_mapper.sv
hdl/rx_decode_fsm.sv
hdl/pcs_rx_decoder.sv
verification/pcs_rx_decoder_assertions.sv
verification/pcs_rx_checker.sv
verification/pcs_rx_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pcs_rx_decoder_tb \
	-f sources.f -o sim_pcs_rx

# the log is judged below, so a nonzero exit from the run is not fatal here
./obj_dir/sim_pcs_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
